/* Makefile */
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --assert --top-module tb_rv_core -f flist.f -Mdir $(BUILD_DIR) -o vsim
	$(BUILD_DIR)/vsim | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+include
source/rv_core_pkg.sv
source/inst_decoder.sv
source/register_file.sv
source/load_store_unit.sv
source/rv_core_top.sv
testbench/rv_core_checker.sv
testbench/tb_rv_core.sv

/* include/rv_core_defs.svh */
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// datapath widths
`define RV_XLEN        32
`define RV_REG_ADDR_W  5

// first fetch address after reset
`define RV_RESET_PC    32'h8000_0000

// major opcodes, inst[6:0]
`define RV_OP_IMM      7'b001_0011
`define RV_OP_LUI      7'b011_0111
`define RV_OP_AUIPC    7'b001_0111
`define RV_OP_JAL      7'b110_1111
`define RV_OP_JALR     7'b110_0111
`define RV_OP_LOAD     7'b000_0011
`define RV_OP_STORE    7'b010_0011
`define RV_OP_SYSTEM   7'b111_0011

// funct3 access widths, standard rv32i codes
`define RV_F3_B        3'b000
`define RV_F3_H        3'b001
`define RV_F3_W        3'b010
`define RV_F3_BU       3'b100
`define RV_F3_HU       3'b101

`endif

/* source/inst_decoder.sv */
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module inst_decoder (
  input  logic [`RV_XLEN-1:0] inst,
  output rv_core_pkg::ctrl_t  ctrl
);

  logic [6:0]          opcode;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  assign opcode = inst[6:0];

  // immediate formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000}; // already shifted
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl        = '0;
    ctrl.rs1    = inst[19:15];
    ctrl.rs2    = inst[24:20];
    ctrl.rd     = inst[11:7];
    ctrl.funct3 = inst[14:12];
    ctrl.imm    = imm_i;
    ctrl.wb_sel = rv_core_pkg::WB_ADDER;

    case (opcode)
      `RV_OP_IMM: begin
        ctrl.reg_write = (inst[14:12] == 3'b000); // addi only
      end
      `RV_OP_LUI: begin
        ctrl.rs1       = '0; // x0 + imm gives the upper immediate
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      `RV_OP_AUIPC: begin
        ctrl.op_a_pc   = 1'b1;
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      `RV_OP_JAL: begin
        ctrl.op_a_pc   = 1'b1;
        ctrl.imm       = imm_j;
        ctrl.jump      = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = rv_core_pkg::WB_LINK;
      end
      `RV_OP_JALR: begin
        ctrl.jump      = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = rv_core_pkg::WB_LINK;
      end
      `RV_OP_LOAD: begin
        ctrl.mem_read  = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = rv_core_pkg::WB_LOAD;
      end
      `RV_OP_STORE: begin
        ctrl.imm       = imm_s;
        ctrl.mem_write = 1'b1;
      end
      `RV_OP_SYSTEM: begin
        // ebreak is imm 1 with all other fields zero
        ctrl.halt = (inst[31:7] == {12'h001, 13'h0000});
      end
      default: ; // unknown opcode does nothing
    endcase
  end

endmodule

/* source/load_store_unit.sv */
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module load_store_unit (
  input  logic [`RV_XLEN-1:0]   addr,
  input  logic [2:0]            funct3,
  input  logic [`RV_XLEN-1:0]   store_data,
  input  logic                  do_load,
  input  logic                  do_store,
  input  logic [`RV_XLEN-1:0]   mem_rdata,
  output rv_core_pkg::mem_req_t mem_req,
  output logic [`RV_XLEN-1:0]   load_data
);

  logic [1:0]          offset;
  logic                aligned;
  logic                store_ok;
  logic [3:0]          store_mask;
  logic [`RV_XLEN-1:0] store_lanes;
  logic [7:0]          byte_sel;
  logic [15:0]         half_sel;

  assign offset = addr[1:0];

  // natural alignment per access width
  always_comb begin
    case (funct3)
      `RV_F3_B, `RV_F3_BU: aligned = 1'b1;
      `RV_F3_H, `RV_F3_HU: aligned = ~offset[0];
      `RV_F3_W:            aligned = (offset == 2'b00);
      default:             aligned = 1'b0;
    endcase
  end

  // unsigned codes are load only
  assign store_ok = aligned && (funct3 inside {`RV_F3_B, `RV_F3_H, `RV_F3_W});

  always_comb begin
    store_mask  = '0;
    store_lanes = '0;
    case (funct3)
      `RV_F3_B: begin
        store_mask  = 4'b0001 << offset;
        store_lanes = {24'h0, store_data[7:0]} << {offset, 3'b000};
      end
      `RV_F3_H: begin
        store_mask  = offset[1] ? 4'b1100 : 4'b0011;
        store_lanes = {16'h0, store_data[15:0]} << {offset[1], 4'b0000};
      end
      `RV_F3_W: begin
        store_mask  = 4'b1111;
        store_lanes = store_data;
      end
      default: ;
    endcase
  end

  assign mem_req.addr  = addr;
  assign mem_req.wdata = store_lanes;
  assign mem_req.wmask = (do_store && store_ok) ? store_mask : 4'b0000;
  assign mem_req.read  = do_load && aligned;
  assign mem_req.write = do_store && store_ok;

  // pick the addressed byte / half out of the word
  assign byte_sel = 8'(mem_rdata >> {offset, 3'b000});
  assign half_sel = offset[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  always_comb begin
    case (funct3)
      `RV_F3_B:  load_data = {{24{byte_sel[7]}}, byte_sel};
      `RV_F3_BU: load_data = {24'h0, byte_sel};
      `RV_F3_H:  load_data = {{16{half_sel[15]}}, half_sel};
      `RV_F3_HU: load_data = {16'h0, half_sel};
      `RV_F3_W:  load_data = mem_rdata;
      default:   load_data = '0;
    endcase
    if (!aligned) load_data = '0; // nothing was read
  end

  // sampled once the inputs have settled in the time step
  always_comb begin
    misaligned_req: assert final (!(do_load || do_store) || aligned)
      else $error("load_store_unit: misaligned access at %h, funct3 %b", addr, funct3);
  end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module register_file (
  input  logic                      clk,
  input  logic                      we,
  input  logic [`RV_REG_ADDR_W-1:0] waddr,
  input  logic [`RV_REG_ADDR_W-1:0] raddr1,
  input  logic [`RV_REG_ADDR_W-1:0] raddr2,
  input  logic [`RV_XLEN-1:0]       wdata,
  output logic [`RV_XLEN-1:0]       rdata1,
  output logic [`RV_XLEN-1:0]       rdata2
);

  logic [`RV_XLEN-1:0] regs [(1 << `RV_REG_ADDR_W)];

  always_ff @(posedge clk) begin
    regs[0] <= '0; // x0 cleared every cycle
    if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // asynchronous read ports
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  // after any write, a port that addresses x0 still reads zero
  x0_stays_zero: assert property (@(posedge clk)
    we |=> ((raddr1 != '0) || (rdata1 == '0)) && ((raddr2 != '0) || (rdata2 == '0)))
    else $error("register_file: x0 read back nonzero");

endmodule

/* source/rv_core_pkg.sv */
`include "rv_core_defs.svh"

package rv_core_pkg;

  // where the register write data comes from
  typedef enum logic [1:0] {
    WB_ADDER = 2'd0, // address adder result
    WB_LINK  = 2'd1, // pc + 4 for jal/jalr
    WB_LOAD  = 2'd2  // extended load data
  } wb_sel_e;

  // decoded instruction, one per cycle
  typedef struct packed {
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [2:0]                funct3;
    logic [`RV_XLEN-1:0]       imm;       // already sign extended
    logic                      op_a_pc;   // adder operand a is pc
    logic                      reg_write;
    logic                      mem_read;
    logic                      mem_write;
    logic                      jump;      // adder result is next pc
    wb_sel_e                   wb_sel;
    logic                      halt;
  } ctrl_t;

  // data memory request, read data returns in the same cycle
  typedef struct packed {
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
    logic [3:0]          wmask;           // one bit per byte lane
    logic                read;
    logic                write;
  } mem_req_t;

endpackage

/* source/rv_core_top.sv */
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`RV_XLEN-1:0]   inst,
  output logic [`RV_XLEN-1:0]   pc,
  output rv_core_pkg::mem_req_t mem_req,
  input  logic [`RV_XLEN-1:0]   mem_rdata,
  output logic                  halt
);

  rv_core_pkg::ctrl_t  ctrl;
  logic                active;      // not in reset and not halted
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] sum;         // shared address adder
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] next_pc;
  logic [`RV_XLEN-1:0] load_data;
  logic [`RV_XLEN-1:0] wb_data;

  inst_decoder u_decoder (
    .inst (inst),
    .ctrl (ctrl)
  );

  assign active = ~reset & ~halt;

  register_file u_regs (
    .clk    (clk),
    .we     (ctrl.reg_write & active),
    .waddr  (ctrl.rd),
    .raddr1 (ctrl.rs1),
    .raddr2 (ctrl.rs2),
    .wdata  (wb_data),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  assign op_a     = ctrl.op_a_pc ? pc : rs1_data;
  assign sum      = op_a + ctrl.imm;
  assign pc_plus4 = pc + `RV_XLEN'd4;
  assign next_pc  = ctrl.jump ? {sum[`RV_XLEN-1:1], 1'b0} : pc_plus4; // jalr clears bit 0

  load_store_unit u_lsu (
    .addr       (sum),
    .funct3     (ctrl.funct3),
    .store_data (rs2_data),
    .do_load    (ctrl.mem_read & active),
    .do_store   (ctrl.mem_write & active),
    .mem_rdata  (mem_rdata),
    .mem_req    (mem_req),
    .load_data  (load_data)
  );

  always_comb begin
    case (ctrl.wb_sel)
      rv_core_pkg::WB_LINK: wb_data = pc_plus4;
      rv_core_pkg::WB_LOAD: wb_data = load_data;
      default:              wb_data = sum;
    endcase
  end

  // pc and the sticky halt level
  always_ff @(posedge clk) begin
    if (reset) begin
      pc   <= `RV_RESET_PC;
      halt <= 1'b0;
    end else if (!halt) begin
      if (ctrl.halt) begin
        halt <= 1'b1; // ebreak, pc stays on it
      end else begin
        pc <= next_pc;
      end
    end
  end

  pc_word_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("rv_core_top: pc %h not word aligned", pc);

endmodule

/* testbench/rv_core_checker.sv */
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core_checker (
  input logic                  clk,
  input logic                  reset,
  input logic [`RV_XLEN-1:0]   pc,
  input rv_core_pkg::mem_req_t mem_req,
  input logic                  halt
);

  typedef struct packed {
    logic [15:0] index;
    logic [31:0] next_pc;
    logic        st_valid;
    logic [31:0] st_addr;
    logic [31:0] st_data;
    logic [3:0]  st_mask;
    logic        ld_valid;
    logic        halt;
  } expect_t;

  expect_t     pending [$]; // filled by the stimulus loop
  expect_t     cur;
  logic [31:0] want_pc;     // pc the current entry must run at
  logic [31:0] lanes;
  int          errs;
  int          pass_count = 0;
  int          fail_count = 0;
  int          other_errors = 0;

  task automatic push_expect(input int index, input logic [31:0] next_pc,
                             input logic st_valid, input logic [31:0] st_addr,
                             input logic [31:0] st_data, input logic [3:0] st_mask,
                             input logic ld_valid, input logic exp_halt);
    expect_t e;
    e.index    = 16'(index);
    e.next_pc  = next_pc;
    e.st_valid = st_valid;
    e.st_addr  = st_addr;
    e.st_data  = st_data;
    e.st_mask  = st_mask;
    e.ld_valid = ld_valid;
    e.halt     = exp_halt;
    pending.push_back(e);
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got,
                         inout int count);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
      count++;
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      want_pc = `RV_RESET_PC;
      if (mem_req.write !== 1'b0) begin
        $display("memory write issued while reset was asserted, t=%0t", $time);
        other_errors++;
      end
    end else if (pending.size() > 0) begin
      cur  = pending.pop_front();
      errs = 0;
      compare("pc", want_pc, pc, errs);
      compare("halt", {31'h0, cur.halt}, {31'h0, halt}, errs);
      compare("mem_req.write", {31'h0, cur.st_valid}, {31'h0, mem_req.write}, errs);
      compare("mem_req.read", {31'h0, cur.ld_valid}, {31'h0, mem_req.read}, errs);
      if (cur.st_valid) begin
        // only the enabled byte lanes carry data
        lanes = {{8{cur.st_mask[3]}}, {8{cur.st_mask[2]}}, {8{cur.st_mask[1]}},
                 {8{cur.st_mask[0]}}};
        compare("mem_req.addr", cur.st_addr, mem_req.addr, errs);
        compare("mem_req.wmask", {28'h0, cur.st_mask}, {28'h0, mem_req.wmask}, errs);
        compare("mem_req.wdata", cur.st_data & lanes, mem_req.wdata & lanes, errs);
      end
      want_pc = cur.next_pc;
      if (errs == 0) begin
        pass_count++;
        $display("entry %0d ok at pc %h", cur.index, pc);
      end else begin
        fail_count++;
        $display("entry %0d had %0d mismatches", cur.index, errs);
      end
    end
  end

endmodule

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module tb_rv_core;

  localparam int          MAX_ENTRIES = 64;
  localparam logic [31:0] LCG_SEED    = 32'h0ca82361;
  localparam logic [31:0] NOP         = 32'h0000_0013; // addi x0, x0, 0
  localparam logic [31:0] EBREAK      = 32'h0010_0073;

  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] next_pc;
    logic        st_valid;
    logic [31:0] st_addr;
    logic [31:0] st_data;
    logic [3:0]  st_mask;
    logic        ld_valid;
    logic        halt;
  } entry_t;

  logic                  clk;
  logic                  reset;
  logic [31:0]           inst;
  logic [31:0]           pc;
  rv_core_pkg::mem_req_t mem_req;
  logic [31:0]           mem_rdata;
  logic                  halt;

  entry_t      tbl [MAX_ENTRIES];
  int          n_entries;
  logic [31:0] shadow [32];  // expected register contents
  logic [31:0] build_pc;
  logic        build_halted;
  logic [31:0] lcg_state;
  logic [31:0] dmem [256];
  logic        table_ready = 1'b0;

  rv_core_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .inst      (inst),
    .pc        (pc),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata),
    .halt      (halt)
  );

  rv_core_checker u_checker (
    .clk     (clk),
    .reset   (reset),
    .pc      (pc),
    .mem_req (mem_req),
    .halt    (halt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // every word differs by index, mixes bytes with the top bit set and clear
  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {idx ^ 8'h4b, idx + 8'h5a, ~idx, idx | 8'h80};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                        input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
  endfunction

  // data memory, combinational read and byte-masked write
  assign mem_rdata = dmem[mem_req.addr[9:2]];

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 256; i++) dmem[i] <= fill_word(8'(i));
    end else if (mem_req.write) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_req.wmask[b]) dmem[mem_req.addr[9:2]][8*b +: 8] <= mem_req.wdata[8*b +: 8];
      end
    end
  end

  // once halted, pc holds and nothing is written
  task automatic add_entry(input logic [31:0] word, input logic [31:0] target,
                           input logic [4:0] rd, input logic [31:0] rd_val,
                           input logic st_valid, input logic [31:0] st_addr,
                           input logic [31:0] st_data, input logic [3:0] st_mask);
    entry_t e;
    e          = '0;
    e.inst     = word;
    e.halt     = build_halted;
    e.next_pc  = build_halted ? build_pc : target;
    e.st_valid = st_valid & ~build_halted;
    e.st_addr  = st_addr;
    e.st_data  = st_data;
    e.st_mask  = st_mask;
    if (!build_halted && rd != 5'd0) shadow[rd] = rd_val;
    tbl[n_entries] = e;
    n_entries++;
    build_pc = e.next_pc;
  endtask

  task automatic put_addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    add_entry(enc_i(`RV_OP_IMM, rd, 3'b000, rs1, imm), build_pc + 32'd4, rd,
              shadow[rs1] + sext12(imm), 1'b0, 32'h0, 32'h0, 4'h0);
  endtask

  task automatic put_upper(input logic [6:0] op, input logic [4:0] rd, input logic [19:0] imm);
    logic [31:0] val;
    val = {imm, 12'h000};
    if (op == `RV_OP_AUIPC) val = val + build_pc;
    add_entry({imm, rd, op}, build_pc + 32'd4, rd, val, 1'b0, 32'h0, 32'h0, 4'h0);
  endtask

  task automatic put_store(input logic [2:0] f3, input logic [4:0] rs2, input logic [4:0] rs1,
                           input logic [11:0] imm);
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
    addr = shadow[rs1] + sext12(imm);
    case (f3)
      `RV_F3_B: begin
        mask = 4'b0001 << addr[1:0];
        data = {4{shadow[rs2][7:0]}}; // checker looks at the masked lane only
      end
      `RV_F3_H: begin
        mask = addr[1] ? 4'b1100 : 4'b0011;
        data = {2{shadow[rs2][15:0]}};
      end
      default: begin
        mask = 4'b1111;
        data = shadow[rs2];
      end
    endcase
    add_entry(enc_s(f3, rs2, rs1, imm), build_pc + 32'd4, 5'd0, 32'h0, 1'b1, addr, data, mask);
  endtask

  task automatic put_load(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
    logic [31:0] addr;
    logic [31:0] word;
    logic [7:0]  bsel;
    logic [15:0] hsel;
    logic [31:0] val;
    addr = shadow[rs1] + sext12(imm);
    word = fill_word(addr[9:2]);
    bsel = word[{addr[1:0], 3'b000} +: 8];
    hsel = word[{addr[1], 4'b0000} +: 16];
    case (f3)
      `RV_F3_B:  val = {{24{bsel[7]}}, bsel};
      `RV_F3_BU: val = {24'h0, bsel};
      `RV_F3_H:  val = {{16{hsel[15]}}, hsel};
      `RV_F3_HU: val = {16'h0, hsel};
      default:   val = word;
    endcase
    add_entry(enc_i(`RV_OP_LOAD, rd, f3, rs1, imm), build_pc + 32'd4, rd, val,
              1'b0, 32'h0, 32'h0, 4'h0);
    tbl[n_entries-1].ld_valid = ~build_halted; // a load reads memory unless halted
  endtask

  task automatic put_jal(input logic [4:0] rd, input logic [20:0] off);
    add_entry({off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL},
              build_pc + {{11{off[20]}}, off}, rd, build_pc + 32'd4, 1'b0, 32'h0, 32'h0, 4'h0);
  endtask

  task automatic put_jalr(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    add_entry(enc_i(`RV_OP_JALR, rd, 3'b000, rs1, imm), (shadow[rs1] + sext12(imm)) & ~32'h1,
              rd, build_pc + 32'd4, 1'b0, 32'h0, 32'h0, 4'h0);
  endtask

  task automatic build_program();
    n_entries    = 0;
    build_pc     = `RV_RESET_PC;
    build_halted = 1'b0;
    lcg_state    = LCG_SEED;
    for (int r = 0; r < 32; r++) shadow[r] = 32'h0;
    lcg_state = lcg_next(lcg_state);
    put_addi(5'd1, 5'd0, lcg_state[27:16]);
    put_store(`RV_F3_W, 5'd1, 5'd0, 12'h000);
    lcg_state = lcg_next(lcg_state);
    put_addi(5'd2, 5'd1, lcg_state[27:16]);
    put_store(`RV_F3_W, 5'd2, 5'd0, 12'h004);
    put_upper(`RV_OP_LUI, 5'd3, 20'habcde);
    put_store(`RV_F3_W, 5'd3, 5'd0, 12'h008);
    put_upper(`RV_OP_AUIPC, 5'd4, 20'h12345);
    put_store(`RV_F3_W, 5'd4, 5'd0, 12'h00c);
    for (int o = 0; o < 4; o++) put_store(`RV_F3_B, 5'd2, 5'd0, 12'(16 + o));
    for (int o = 0; o < 4; o += 2) put_store(`RV_F3_H, 5'd2, 5'd0, 12'(20 + o));
    // loads from the preloaded area at 0x200, each result stored back
    for (int o = 0; o < 4; o++) begin
      put_load(`RV_F3_B, 5'd8, 5'd0, 12'(32'h200 + 5 * o));
      put_store(`RV_F3_W, 5'd8, 5'd0, 12'h020);
      put_load(`RV_F3_BU, 5'd9, 5'd0, 12'(32'h200 + 5 * o));
      put_store(`RV_F3_W, 5'd9, 5'd0, 12'h024);
    end
    for (int k = 0; k < 2; k++) begin
      put_load(`RV_F3_H, 5'd8, 5'd0, 12'(32'h210 + 6 * k));
      put_store(`RV_F3_W, 5'd8, 5'd0, 12'h028);
      put_load(`RV_F3_HU, 5'd9, 5'd0, 12'(32'h210 + 6 * k));
      put_store(`RV_F3_W, 5'd9, 5'd0, 12'h02c);
    end
    for (int k = 0; k < 2; k++) begin
      put_load(`RV_F3_W, 5'd8, 5'd0, 12'(32'h220 + 4 * k));
      put_store(`RV_F3_W, 5'd8, 5'd0, 12'h020);
    end
    put_jal(5'd10, 21'h00040);
    put_store(`RV_F3_W, 5'd10, 5'd0, 12'h030);
    put_upper(`RV_OP_LUI, 5'd7, 20'h80000);
    put_addi(5'd7, 5'd7, 12'h101); // odd target, jalr drops bit 0
    put_jalr(5'd11, 5'd7, 12'h000);
    put_store(`RV_F3_W, 5'd11, 5'd0, 12'h034);
    add_entry(EBREAK, build_pc, 5'd0, 32'h0, 1'b0, 32'h0, 32'h0, 4'h0);
    build_halted = 1'b1;
    put_store(`RV_F3_W, 5'd1, 5'd0, 12'h038);
    put_addi(5'd1, 5'd0, 12'h7ff);
    put_store(`RV_F3_W, 5'd1, 5'd0, 12'h03c);
  endtask

  initial begin
    reset = 1'b1;
    inst  = enc_s(`RV_F3_W, 5'd0, 5'd0, 12'h000); // store that reset must block
    build_program();
    table_ready = 1'b1;
    repeat (3) @(posedge clk);
    for (int i = 0; i < n_entries; i++) begin
      #1;
      reset = 1'b0;
      inst  = tbl[i].inst;
      u_checker.push_expect(i, tbl[i].next_pc, tbl[i].st_valid, tbl[i].st_addr,
                            tbl[i].st_data, tbl[i].st_mask, tbl[i].ld_valid, tbl[i].halt);
      @(posedge clk);
    end
    #1;
    inst = NOP;
    $display("%0d tests passed, %0d tests failed, %0d other errors",
             u_checker.pass_count, u_checker.fail_count, u_checker.other_errors);
    if (u_checker.fail_count == 0 && u_checker.other_errors == 0 &&
        u_checker.pass_count == n_entries) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog, sized from the table length
  initial begin
    wait (table_ready);
    #((n_entries + 20) * 4);
    $display("timeout: the run did not finish within %0d cycles", n_entries + 20);
    $display("Test failures found");
    $finish;
  end

endmodule
